// File: hw/arb_pkg.sv
package arb_pkg;

    // scheduler states
    // SCAN walks the slots, ISSUE waits on bmem_ready, WAIT holds until burst done
    typedef enum logic [1:0] {
        SCAN,
        ISSUE,
        WAIT
    } arb_state_e;

    // kind of burst owned by the granted slot
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } burst_op_e;

endpackage

// File: hw/burst_if.sv
interface burst_if;

    // write side, arbiter to serializer
    logic               start_write;
    mem_cfg_pkg::line_t wline;
    logic               write_done;

    // read side, collector to arbiter
    mem_cfg_pkg::line_t rline;
    logic               read_done;

    modport arb (
        output start_write,
        output wline,
        input  write_done,
        input  rline,
        input  read_done
    );

    modport rd (
        output rline,
        output read_done
    );

    modport wr (
        input  start_write,
        input  wline,
        output write_done
    );

endinterface

// File: hw/burst_reader.sv
module burst_reader (
    input  logic               clk,
    input  logic               rst,
    input  mem_cfg_pkg::beat_t bmem_rdata,
    input  logic               bmem_rvalid,
    burst_if.rd                bus
);

    localparam mem_cfg_pkg::beat_cnt_t LAST_BEAT =
        mem_cfg_pkg::beat_cnt_t'(mem_cfg_pkg::BEATS_PER_LINE - 1);
    localparam int LOW_W = mem_cfg_pkg::LINE_W - mem_cfg_pkg::BEAT_W;

    mem_cfg_pkg::beat_cnt_t beat_cnt;

    // lower beats, the top one goes straight into rline
    logic [LOW_W-1:0]       low_beats;

    // beat counter and completion flag
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt      <= '0;
            bus.read_done <= 1'b0;
        end else begin
            bus.read_done <= 1'b0;
            if (bmem_rvalid) begin
                if (beat_cnt == LAST_BEAT) begin
                    beat_cnt      <= '0;
                    bus.read_done <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // beats may arrive with gaps, each lands in its own quarter
    always_ff @(posedge clk) begin
        if (bmem_rvalid) begin
            if (beat_cnt == LAST_BEAT) begin
                bus.rline <= {bmem_rdata, low_beats};
            end else begin
                low_beats[beat_cnt*mem_cfg_pkg::BEAT_W +: mem_cfg_pkg::BEAT_W] <= bmem_rdata;
            end
        end
    end

endmodule

// File: hw/burst_writer.sv
module burst_writer (
    input  logic               clk,
    input  logic               rst,
    output mem_cfg_pkg::beat_t bmem_wdata,
    burst_if.wr                bus
);

    localparam mem_cfg_pkg::beat_cnt_t LAST_BEAT =
        mem_cfg_pkg::beat_cnt_t'(mem_cfg_pkg::BEATS_PER_LINE - 1);

    mem_cfg_pkg::line_t     line_q;
    mem_cfg_pkg::beat_cnt_t beat_cnt;
    logic                   busy;

    // busy covers beats 1..3, beat 0 leaves in the command cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= 1'b0;
            beat_cnt       <= '0;
            bus.write_done <= 1'b0;
        end else begin
            bus.write_done <= 1'b0;
            if (bus.start_write) begin
                busy     <= 1'b1;
                beat_cnt <= mem_cfg_pkg::beat_cnt_t'(1);
            end else if (busy) begin
                if (beat_cnt == LAST_BEAT) begin
                    busy           <= 1'b0;
                    beat_cnt       <= '0;
                    bus.write_done <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // snapshot so the requester may change wline mid-burst
    always_ff @(posedge clk) begin
        if (bus.start_write) begin
            line_q <= bus.wline;
        end
    end

    assign bmem_wdata = busy ? line_q[beat_cnt*mem_cfg_pkg::BEAT_W +: mem_cfg_pkg::BEAT_W]
                             : bus.wline[mem_cfg_pkg::BEAT_W-1:0];

endmodule

// File: hw/line_arbiter.sv
module line_arbiter #(
    parameter int NUM_REQ = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  mem_cfg_pkg::addr_t req_addr  [NUM_REQ],
    input  logic [NUM_REQ-1:0] req_read,
    input  logic [NUM_REQ-1:0] req_write,
    input  mem_cfg_pkg::line_t req_wdata [NUM_REQ],
    output mem_cfg_pkg::line_t req_rdata [NUM_REQ],
    output logic [NUM_REQ-1:0] req_resp,

    output mem_cfg_pkg::addr_t bmem_addr,
    output logic               bmem_read,
    output logic               bmem_write,
    input  logic               bmem_ready,

    burst_if.arb               bus
);

    localparam int IDX_W = $clog2(NUM_REQ);
    localparam logic [IDX_W-1:0] LAST_SLOT = IDX_W'(NUM_REQ - 1);

    arb_pkg::arb_state_e state;
    arb_pkg::burst_op_e  op;
    logic [IDX_W-1:0]    scan_ptr;
    logic [IDX_W-1:0]    grant;
    logic                issue_fire;
    logic                burst_done;
    logic                read_resp;

    // last line returned to each slot
    mem_cfg_pkg::line_t  rdata_q [NUM_REQ];

    // next slot in rotation, wraps for any slot count
    function automatic logic [IDX_W-1:0] wrap_inc(input logic [IDX_W-1:0] slot);
        logic [IDX_W-1:0] nxt;
        if (slot == LAST_SLOT) begin
            nxt = '0;
        end else begin
            nxt = slot + 1'b1;
        end
        return nxt;
    endfunction

    // command goes out in the single ISSUE cycle that sees ready
    assign issue_fire = (state == arb_pkg::ISSUE) && bmem_ready;
    assign bmem_read  = issue_fire && (op == arb_pkg::OP_READ);
    assign bmem_write = issue_fire && (op == arb_pkg::OP_WRITE);

    // requester holds its address, so this stays put under back-pressure
    assign bmem_addr = {req_addr[grant][mem_cfg_pkg::ADDR_W-1:mem_cfg_pkg::LINE_OFFSET_W],
                        {mem_cfg_pkg::LINE_OFFSET_W{1'b0}}};

    assign bus.start_write = bmem_write;
    assign bus.wline       = req_wdata[grant];

    assign burst_done = (state == arb_pkg::WAIT)
                      && ((op == arb_pkg::OP_READ && bus.read_done)
                       || (op == arb_pkg::OP_WRITE && bus.write_done));
    assign read_resp  = burst_done && (op == arb_pkg::OP_READ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= arb_pkg::SCAN;
            op       <= arb_pkg::OP_NONE;
            scan_ptr <= '0;
            grant    <= '0;
        end else begin
            unique case (state)
                arb_pkg::SCAN: begin
                    if (req_read[scan_ptr] || req_write[scan_ptr]) begin
                        grant <= scan_ptr;
                        op    <= req_write[scan_ptr] ? arb_pkg::OP_WRITE : arb_pkg::OP_READ;
                        state <= arb_pkg::ISSUE;
                    end else begin
                        scan_ptr <= wrap_inc(scan_ptr);
                    end
                end
                arb_pkg::ISSUE: begin
                    if (bmem_ready) begin
                        state <= arb_pkg::WAIT;
                    end
                end
                arb_pkg::WAIT: begin
                    // resume scanning just past the slot we served
                    if (burst_done) begin
                        state    <= arb_pkg::SCAN;
                        op       <= arb_pkg::OP_NONE;
                        scan_ptr <= wrap_inc(grant);
                    end
                end
                default: state <= arb_pkg::SCAN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_resp) begin
            rdata_q[grant] <= bus.rline;
        end
    end

    // one-cycle response to the granted slot only
    always_comb begin
        req_resp = '0;
        if (burst_done) begin
            req_resp[grant] = 1'b1;
        end
    end

    // fresh line shows in the resp cycle, then the stored copy holds it
    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            req_rdata[i] = rdata_q[i];
        end
        if (read_resp) begin
            req_rdata[grant] = bus.rline;
        end
    end

endmodule

// File: hw/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // memory port geometry
    localparam int ADDR_W = 32;
    localparam int BEAT_W = 64;
    localparam int LINE_W = 256;

    // one line is moved as this many beats
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;

    // byte offset bits inside a 32-byte line
    localparam int LINE_OFFSET_W = 5;

    // byte address as seen by requesters and memory
    typedef logic [ADDR_W-1:0] addr_t;

    // single transfer on the memory data bus
    typedef logic [BEAT_W-1:0] beat_t;

    // full cache line, beat 0 in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // beat index within a line
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

endpackage

// File: hw/mem_subsystem.sv
module mem_subsystem #(
    parameter int NUM_REQ = 4
) (
    input  logic               clk,
    input  logic               rst,

    // requester slots
    // 0,1 ooo core icache/dcache and 2,3 pipelined core icache/dcache
    input  mem_cfg_pkg::addr_t req_addr  [NUM_REQ],
    input  logic [NUM_REQ-1:0] req_read,
    input  logic [NUM_REQ-1:0] req_write,
    input  mem_cfg_pkg::line_t req_wdata [NUM_REQ],
    output mem_cfg_pkg::line_t req_rdata [NUM_REQ],
    output logic [NUM_REQ-1:0] req_resp,

    // burst memory port
    output mem_cfg_pkg::addr_t bmem_addr,
    output logic               bmem_read,
    output logic               bmem_write,
    output mem_cfg_pkg::beat_t bmem_wdata,
    input  logic               bmem_ready,
    input  mem_cfg_pkg::beat_t bmem_rdata,
    input  logic               bmem_rvalid
);

    burst_if bus_i ();

    // scheduler owns the command side and response routing
    line_arbiter #(
        .NUM_REQ (NUM_REQ)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req_addr   (req_addr),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .req_rdata  (req_rdata),
        .req_resp   (req_resp),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_ready (bmem_ready),
        .bus        (bus_i.arb)
    );

    burst_reader u_reader (
        .clk         (clk),
        .rst         (rst),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .bus         (bus_i.rd)
    );

    // write data path is the only memory output not from the arbiter
    burst_writer u_writer (
        .clk        (clk),
        .rst        (rst),
        .bmem_wdata (bmem_wdata),
        .bus        (bus_i.wr)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, pass or fail decided from the log
verilator --binary --timing --assert -j 0 --top-module tb_top -f sources.f -o Vtb_top \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sources.f
hw/mem_cfg_pkg.sv
hw/arb_pkg.sv
hw/burst_if.sv
hw/line_arbiter.sv
hw/burst_reader.sv
hw/burst_writer.sv
hw/mem_subsystem.sv
tb/tb_mem_model.sv
tb/mem_subsystem_asserts.sv
tb/tb_top.sv

// File: tb/mem_subsystem_asserts.sv
module mem_subsystem_asserts #(
    parameter int NUM_REQ = 4
) (
    input logic               clk,
    input logic               rst,
    input logic [NUM_REQ-1:0] req_read,
    input logic [NUM_REQ-1:0] req_write,
    input logic [NUM_REQ-1:0] req_resp,
    input mem_cfg_pkg::addr_t bmem_addr,
    input logic               bmem_read,
    input logic               bmem_write,
    input logic               bmem_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        outstanding;
    logic        req_seen;
    int unsigned fail_count = 0;

    // one burst in flight from command to response
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (bmem_read || bmem_write) begin
            outstanding <= 1'b1;
        end else if (req_resp != '0) begin
            outstanding <= 1'b0;
        end
    end

    // some slot has asked for a line since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            req_seen <= 1'b0;
        end else if ((req_read | req_write) != '0) begin
            req_seen <= 1'b1;
        end
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> (!bmem_read && !bmem_write && req_resp == '0))
        else begin
            $error("memory command or response before any request");
            fail_count++;
        end

    resp_to_pending: assert property (@(posedge clk) disable iff (rst)
        (req_resp & ~(req_read | req_write)) == '0)
        else begin
            $error("response to a slot without a pending request");
            fail_count++;
        end

    resp_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(req_resp))
        else begin
            $error("more than one slot responded in a cycle");
            fail_count++;
        end

    // write response lands four cycles after the command
    write_timing: assert property (@(posedge clk) disable iff (rst)
        bmem_write |-> ##1 (req_resp == '0) ##1 (req_resp == '0)
                       ##1 (req_resp == '0) ##1 (req_resp != '0))
        else begin
            $error("write response not four cycles after the command");
            fail_count++;
        end

    no_cmd_when_busy: assert property (@(posedge clk) disable iff (rst)
        !bmem_ready |-> (!bmem_read && !bmem_write))
        else begin
            $error("command issued while memory not ready");
            fail_count++;
        end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> $stable(bmem_addr))
        else begin
            $error("memory address changed during a burst");
            fail_count++;
        end

    single_burst: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) |-> !outstanding)
        else begin
            $error("second command before the previous response");
            fail_count++;
        end

endmodule

bind mem_subsystem mem_subsystem_asserts #(.NUM_REQ(NUM_REQ)) u_asserts (.*);

// File: tb/tb_mem_model.sv
module tb_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  mem_cfg_pkg::addr_t bmem_addr,
    input  logic               bmem_read,
    input  logic               bmem_write,
    input  mem_cfg_pkg::beat_t bmem_wdata,
    output logic               bmem_ready,
    output mem_cfg_pkg::beat_t bmem_rdata,
    output logic               bmem_rvalid
);

    timeunit 1ns;
    timeprecision 1ps;

    // stored lines by line address
    mem_cfg_pkg::line_t mem [mem_cfg_pkg::addr_t];

    logic               ready_q = 1'b0;
    logic               rvalid_q = 1'b0;
    mem_cfg_pkg::beat_t rdata_q = '0;
    logic [31:0]        rand_state = 32'd1;

    // read command bookkeeping, counted on both edges
    int unsigned        rd_cmds = 0;
    int unsigned        rd_served = 0;
    mem_cfg_pkg::addr_t rd_addr = '0;
    logic               rd_active = 1'b0;
    int                 rd_wait = 0;
    int                 rd_beat = 0;

    mem_cfg_pkg::addr_t wr_addr = '0;
    mem_cfg_pkg::line_t wr_line = '0;
    int                 wr_beat = 0;

    assign bmem_ready  = ready_q;
    assign bmem_rvalid = rvalid_q;
    assign bmem_rdata  = rdata_q;

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {16'd0, rand_state[30:15]};
    endfunction

    // unwritten memory: beat address high, its inverse low
    function automatic mem_cfg_pkg::beat_t read_beat(input mem_cfg_pkg::addr_t line_addr,
                                                     input int beat);
        mem_cfg_pkg::addr_t a;
        mem_cfg_pkg::beat_t b;
        if (mem.exists(line_addr)) begin
            b = mem[line_addr][beat*64 +: 64];
        end else begin
            a = line_addr + mem_cfg_pkg::addr_t'(beat * 8);
            b = {a, ~a};
        end
        return b;
    endfunction

    // commands and write beats are taken on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_cmds = 0;
            wr_beat = 0;
        end else begin
            if (bmem_read) begin
                rd_addr = bmem_addr;
                rd_cmds = rd_cmds + 1;
            end
            if (bmem_write) begin
                wr_addr        = bmem_addr;
                wr_line[63:0]  = bmem_wdata;
                wr_beat        = 1;
            end else if (wr_beat >= 1 && wr_beat <= 3) begin
                wr_line[wr_beat*64 +: 64] = bmem_wdata;
                wr_beat = wr_beat + 1;
                if (wr_beat == 4) begin
                    mem[wr_addr] = wr_line;
                end
            end
        end
    end

    // ready gaps, latency and beat gaps all come from the generator
    always @(negedge clk) begin
        if (rst) begin
            ready_q   = 1'b0;
            rvalid_q  = 1'b0;
            rd_active = 1'b0;
            rd_served = 0;
        end else begin
            ready_q  = (next_rand() % 4) != 0;
            rvalid_q = 1'b0;
            if (!rd_active && rd_cmds != rd_served) begin
                rd_active = 1'b1;
                rd_wait   = int'(next_rand() % 5);
                rd_beat   = 0;
            end else if (rd_active) begin
                if (rd_wait > 0) begin
                    rd_wait = rd_wait - 1;
                end else if ((next_rand() % 3) != 0) begin
                    rvalid_q = 1'b1;
                    rdata_q  = read_beat(rd_addr, rd_beat);
                    rd_beat  = rd_beat + 1;
                    if (rd_beat == 4) begin
                        rd_active = 1'b0;
                        rd_served = rd_served + 1;
                    end
                end
            end
        end
    end

endmodule

// File: tb/tb_top.sv
module tb_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ = 4;
    localparam int TIMEOUT = 3000;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    mem_cfg_pkg::addr_t req_addr  [NUM_REQ];
    logic [NUM_REQ-1:0] req_read;
    logic [NUM_REQ-1:0] req_write;
    mem_cfg_pkg::line_t req_wdata [NUM_REQ];
    mem_cfg_pkg::line_t req_rdata [NUM_REQ];
    logic [NUM_REQ-1:0] req_resp;
    mem_cfg_pkg::addr_t bmem_addr;
    logic               bmem_read;
    logic               bmem_write;
    mem_cfg_pkg::beat_t bmem_wdata;
    logic               bmem_ready;
    mem_cfg_pkg::beat_t bmem_rdata;
    logic               bmem_rvalid;

    int                 data_errors = 0;
    int                 timeouts = 0;
    logic [31:0]        rand_state = 32'd1;
    mem_cfg_pkg::line_t shadow [mem_cfg_pkg::addr_t];
    mem_cfg_pkg::addr_t cmd_log [$];
    mem_cfg_pkg::line_t wlog [$];
    mem_cfg_pkg::line_t wcap = '0;
    int                 wcap_idx = 0;

    mem_subsystem #(.NUM_REQ(NUM_REQ)) DUT (.*);

    tb_mem_model u_mem (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    // command order and write beats as seen on the memory port
    always @(posedge clk) begin
        if (bmem_read || bmem_write) begin
            cmd_log.push_back(bmem_addr);
        end
        if (bmem_write) begin
            wcap[63:0] = bmem_wdata;
            wcap_idx   = 1;
        end else if (wcap_idx >= 1 && wcap_idx <= 3) begin
            wcap[wcap_idx*64 +: 64] = bmem_wdata;
            wcap_idx = wcap_idx + 1;
            if (wcap_idx == 4) begin
                wlog.push_back(wcap);
            end
        end
    end

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {16'd0, rand_state[30:15]};
    endfunction

    function automatic mem_cfg_pkg::line_t expected_line(input mem_cfg_pkg::addr_t addr);
        mem_cfg_pkg::line_t l;
        mem_cfg_pkg::addr_t a;
        if (shadow.exists(addr)) begin
            l = shadow[addr];
        end else begin
            for (int i = 0; i < 4; i++) begin
                a = addr + mem_cfg_pkg::addr_t'(i * 8);
                l[i*64 +: 64] = {a, ~a};
            end
        end
        return l;
    endfunction

    // each slot works in its own 16 MB region
    function automatic mem_cfg_pkg::addr_t slot_addr(input int slot, input int line);
        return (mem_cfg_pkg::addr_t'(slot) << 24) | (mem_cfg_pkg::addr_t'(line) << 5);
    endfunction

    task automatic compare_line(input string name, input mem_cfg_pkg::line_t exp,
                                input mem_cfg_pkg::line_t got);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, got);
            data_errors++;
        end
    endtask

    task automatic access(input int slot, input mem_cfg_pkg::addr_t addr,
                          input logic is_write, input mem_cfg_pkg::line_t wdata,
                          output mem_cfg_pkg::line_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(negedge clk);
        req_addr[slot]  = addr;
        req_wdata[slot] = wdata;
        req_read[slot]  = !is_write;
        req_write[slot] = is_write;
        do begin
            @(negedge clk);
            waited++;
        end while (!req_resp[slot] && waited < TIMEOUT);
        if (req_resp[slot]) begin
            rdata = req_rdata[slot];
        end else begin
            $display("timeout: slot %0d got no response for address %h", slot, addr);
            timeouts++;
        end
        // request stays up through the response cycle
        @(negedge clk);
        req_read[slot]  = 1'b0;
        req_write[slot] = 1'b0;
    endtask

    task automatic read_and_check(input string name, input int slot,
                                  input mem_cfg_pkg::addr_t addr);
        mem_cfg_pkg::line_t got;
        access(slot, addr, 1'b0, '0, got);
        compare_line(name, expected_line(addr), got);
    endtask

    task automatic slot_reads(input int slot, input int count);
        for (int k = 0; k < count; k++) begin
            read_and_check("rotation read", slot, slot_addr(slot, k));
        end
    endtask

    task automatic write_and_verify(input int slot, input int line);
        mem_cfg_pkg::line_t data;
        mem_cfg_pkg::line_t dummy;
        mem_cfg_pkg::addr_t addr;
        logic [31:0]        rnd_hi;
        logic [31:0]        rnd_lo;
        addr = slot_addr(slot, line);
        for (int i = 0; i < 8; i++) begin
            rnd_hi = next_rand();
            rnd_lo = next_rand();
            data[i*32 +: 32] = {rnd_hi[15:0], rnd_lo[15:0]};
        end
        wlog.delete();
        access(slot, addr, 1'b1, data, dummy);
        if (wlog.size() == 0) begin
            $display("write beats for slot %0d never appeared on the memory port", slot);
            data_errors++;
        end else begin
            compare_line("write beats", data, wlog.pop_front());
        end
        shadow[addr] = data;
        read_and_check("write readback", slot, addr);
    endtask

    initial begin
        int slot;
        int assert_fail;
        for (int i = 0; i < NUM_REQ; i++) begin
            req_addr[i]  = '0;
            req_wdata[i] = '0;
        end
        req_read  = '0;
        req_write = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // one idle sweep over all slots brings the scan pointer back to slot 0
        repeat (NUM_REQ - 1) @(negedge clk);

        // all slots at once, first grant goes to slot 0
        cmd_log.delete();
        for (int s = 0; s < NUM_REQ; s++) begin
            automatic int sl = s;
            fork
                slot_reads(sl, 2);
            join_none
        end
        wait fork;
        if (cmd_log.size() != 2 * NUM_REQ) begin
            $display("rotation test saw %0d commands instead of %0d",
                     cmd_log.size(), 2 * NUM_REQ);
            data_errors++;
        end
        for (int i = 0; i < cmd_log.size(); i++) begin
            if (int'(cmd_log[i][25:24]) != i % NUM_REQ) begin
                $display("FAILED rotation: expected slot %0d, actual slot %0d",
                         i % NUM_REQ, cmd_log[i][25:24]);
                data_errors++;
            end
        end

        for (int n = 0; n < 12; n++) begin
            slot = int'(next_rand() % NUM_REQ);
            read_and_check("random read", slot, slot_addr(slot, int'(next_rand() % 64)));
        end

        // data cache slots of both cores
        write_and_verify(1, 3);
        write_and_verify(3, 7);
        write_and_verify(1, 40);

        repeat (5) @(negedge clk);
        assert_fail = DUT.u_asserts.fail_count;
        $display("data errors: %0d, timeouts: %0d, assertion failures: %0d",
                 data_errors, timeouts, assert_fail);
        if (data_errors == 0 && timeouts == 0 && assert_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
